/* hdl/flash_defs.svh */
`ifndef FLASH_DEFS_SVH
`define FLASH_DEFS_SVH

//////////////////////////////
// SCK timing
//////////////////////////////

`define FLASH_SCK_HALF      4    // System clocks per SCK half period

//////////////////////////////
// Frame field widths
//////////////////////////////

`define FLASH_OPCODE_BITS   8
`define FLASH_ADDR_BITS     24
`define FLASH_WORD_BITS     32
`define FLASH_STATUS_BITS   8    // RDSR returns one status byte

`endif

/* hdl/flash_pkg.sv */
`default_nettype none

`include "flash_defs.svh"

package flash_pkg;

    // Single-lane SPI NOR instructions
    typedef enum logic [`FLASH_OPCODE_BITS-1:0] {
        OP_PP   = 8'h02,    // Page program
        OP_READ = 8'h03,
        OP_RDSR = 8'h05,    // Read status register
        OP_WREN = 8'h06,
        OP_SE   = 8'h20     // 4 KB sector erase
    } flash_opcode_e;

    // One command frame as handed to the frame engine
    typedef struct packed {
        flash_opcode_e                opcode;
        logic [`FLASH_ADDR_BITS-1:0]  addr;
        logic                         has_addr;
        logic [`FLASH_WORD_BITS-1:0]  tx_data;
        logic                         has_tx;
        logic [5:0]                   rx_bits;     // 0, 8 or 32
    } frame_req_t;

    typedef struct packed {
        logic                         write;       // 1 = program, 0 = read
        logic [`FLASH_ADDR_BITS-1:0]  addr;
        logic [`FLASH_WORD_BITS-1:0]  wdata;
    } host_cmd_t;

    typedef enum logic [2:0] {
        PG_IDLE,
        PG_WREN_ERASE,
        PG_ERASE,
        PG_POLL_ERASE,
        PG_WREN_PROG,
        PG_PROGRAM,
        PG_POLL_PROG
    } prog_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_WAIT
    } rd_state_e;

endpackage

`default_nettype wire

/* hdl/spi_frame_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "flash_defs.svh"

module spi_frame_engine (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         start,
    input  flash_pkg::frame_req_t        req,
    output logic                         done,
    output logic [`FLASH_WORD_BITS-1:0]  rx_data,
    output logic                         busy,
    output logic                         flash_cs_n,
    output logic                         flash_sck,
    output logic                         flash_mosi,
    input  logic                         flash_miso
);

    localparam int TX_BITS = `FLASH_OPCODE_BITS + `FLASH_ADDR_BITS + `FLASH_WORD_BITS;

    logic [TX_BITS-1:0] tx_shift;
    logic [TX_BITS-1:0] tx_load;
    logic [7:0]         presc;
    logic [7:0]         half_idx;      // Half periods elapsed in this frame
    logic [7:0]         last_half;
    logic [6:0]         tx_bits;
    logic [6:0]         n_tx;
    logic [6:0]         n_total;
    logic [6:0]         bit_idx;
    logic               half_tick;
    logic               bit_half;

    //////////////////////////////
    // Frame sizing
    //////////////////////////////

    assign n_tx = 7'(`FLASH_OPCODE_BITS)
                + (req.has_addr ? 7'(`FLASH_ADDR_BITS) : 7'd0)
                + (req.has_tx ? 7'(`FLASH_WORD_BITS) : 7'd0);
    assign n_total = n_tx + {1'b0, req.rx_bits};

    // Left-aligned so the opcode MSB leaves first
    always_comb begin
        case ({req.has_addr, req.has_tx})
            2'b11:   tx_load = {req.opcode, req.addr, req.tx_data};
            2'b10:   tx_load = {req.opcode, req.addr, {`FLASH_WORD_BITS{1'b0}}};
            2'b01:   tx_load = {req.opcode, req.tx_data, {`FLASH_ADDR_BITS{1'b0}}};
            default: tx_load = {req.opcode, {(TX_BITS - `FLASH_OPCODE_BITS){1'b0}}};
        endcase
    end

    assign half_tick  = busy && (presc == 8'd0);
    assign bit_half   = half_idx < (last_half - 8'd2);  // Halves that carry SCK edges
    assign bit_idx    = half_idx[7:1];
    assign flash_mosi = tx_shift[TX_BITS-1];

    //////////////////////////////
    // Sequencing and SCK
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            flash_cs_n <= 1'b1;
            flash_sck  <= 1'b0;
            presc      <= 8'd0;
            half_idx   <= 8'd0;
            tx_shift   <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy       <= 1'b1;
                    flash_cs_n <= 1'b0;    // One half period of setup before SCK
                    presc      <= 8'(`FLASH_SCK_HALF - 1);
                    half_idx   <= 8'd0;
                    tx_shift   <= tx_load;
                end
            end else if (presc != 8'd0) begin
                presc <= presc - 8'd1;
            end else begin
                presc    <= 8'(`FLASH_SCK_HALF - 1);
                half_idx <= half_idx + 8'd1;
                if (bit_half) begin
                    flash_sck <= ~half_idx[0];  // Even half ends with rise
                    if (half_idx[0])
                        tx_shift <= tx_shift << 1;  // Next bit while SCK low
                end else if (half_idx == last_half - 8'd2) begin
                    flash_cs_n <= 1'b1;
                end else if (half_idx == last_half) begin
                    busy <= 1'b0;    // CS has been high two halves
                    done <= 1'b1;
                end
            end
        end
    end

    // Frame length latched at start
    always_ff @(posedge i_clk) begin
        if (!busy && start) begin
            last_half <= {n_total, 1'b0} + 8'd2;
            tx_bits   <= n_tx;
        end
    end

    // MISO sampled on SCK rise in the receive phase
    always_ff @(posedge i_clk) begin
        if (!busy && start)
            rx_data <= '0;
        else if (half_tick && bit_half && !half_idx[0] && bit_idx >= tx_bits)
            rx_data <= {rx_data[`FLASH_WORD_BITS-2:0], flash_miso};
    end

endmodule

`default_nettype wire

/* hdl/frame_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_arbiter (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   rd_req,
    input  logic                   pg_req,
    input  flash_pkg::frame_req_t  rd_frame,
    input  flash_pkg::frame_req_t  pg_frame,
    output logic                   rd_done,
    output logic                   pg_done,
    input  logic                   eng_busy,
    input  logic                   eng_done,
    output logic                   eng_start,
    output flash_pkg::frame_req_t  eng_frame
);

    logic grant_active;
    logic owner;       // 1 = program sequencer
    logic prio;        // Winner on a tie
    logic pick;

    assign pick      = (rd_req && pg_req) ? prio : pg_req;
    assign eng_start = !grant_active && !eng_busy && (rd_req || pg_req);
    assign eng_frame = pick ? pg_frame : rd_frame;  // Sampled by engine on start only

    // Done goes back to the owner alone
    assign rd_done = eng_done && grant_active && !owner;
    assign pg_done = eng_done && grant_active && owner;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            grant_active <= 1'b0;
            owner        <= 1'b0;
            prio         <= 1'b0;
        end else if (eng_start) begin
            grant_active <= 1'b1;
            owner        <= pick;
            prio         <= ~pick;    // Other peer first next time
        end else if (eng_done) begin
            grant_active <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/read_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "flash_defs.svh"

module read_sequencer (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         start,
    input  logic [`FLASH_ADDR_BITS-1:0]  address,
    output logic                         busy,
    output logic                         frame_req,
    output flash_pkg::frame_req_t        frame,
    input  logic                         frame_done,
    input  logic [`FLASH_WORD_BITS-1:0]  rx_data,
    output logic [`FLASH_WORD_BITS-1:0]  word,
    output logic                         valid
);

    import flash_pkg::*;

    rd_state_e                   state;
    logic [`FLASH_ADDR_BITS-1:0] addr_q;

    assign busy      = (state != RD_IDLE);
    assign frame_req = (state == RD_WAIT);

    // READ opcode, address, 32 bits back
    always_comb begin
        frame          = '0;
        frame.opcode   = OP_READ;
        frame.addr     = addr_q;
        frame.has_addr = 1'b1;
        frame.rx_bits  = 6'(`FLASH_WORD_BITS);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= RD_IDLE;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                RD_IDLE: if (start) state <= RD_WAIT;
                RD_WAIT: begin
                    if (frame_done) begin
                        state <= RD_IDLE;
                        valid <= 1'b1;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RD_IDLE && start)
            addr_q <= address;
        if (state == RD_WAIT && frame_done)
            word <= rx_data;    // Held until next read
    end

endmodule

`default_nettype wire

/* hdl/program_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "flash_defs.svh"

module program_sequencer (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         start,
    input  flash_pkg::host_cmd_t         cmd,
    output logic                         busy,
    output logic                         frame_req,
    output flash_pkg::frame_req_t        frame,
    input  logic                         frame_done,
    input  logic [`FLASH_WORD_BITS-1:0]  rx_data,
    output logic                         done
);

    import flash_pkg::*;

    localparam int WIP_BIT = 0;    // Write in progress

    prog_state_e                 state;
    logic [`FLASH_ADDR_BITS-1:0] addr_q;
    logic [`FLASH_WORD_BITS-1:0] data_q;
    logic                        wip_clear;

    assign busy      = (state != PG_IDLE);
    assign frame_req = busy;
    assign wip_clear = frame_done && !rx_data[WIP_BIT];

    //////////////////////////////
    // Frame per step
    //////////////////////////////

    always_comb begin
        frame         = '0;
        frame.addr    = addr_q;
        frame.tx_data = data_q;
        case (state)
            PG_ERASE: begin
                frame.opcode   = OP_SE;
                frame.has_addr = 1'b1;
            end
            PG_POLL_ERASE, PG_POLL_PROG: begin
                frame.opcode  = OP_RDSR;
                frame.rx_bits = 6'(`FLASH_STATUS_BITS);
            end
            PG_PROGRAM: begin
                frame.opcode   = OP_PP;
                frame.has_addr = 1'b1;
                frame.has_tx   = 1'b1;
            end
            default: frame.opcode = OP_WREN;    // Both enable steps
        endcase
    end

    //////////////////////////////
    // Step FSM
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= PG_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                PG_IDLE:       if (start) state <= PG_WREN_ERASE;
                PG_WREN_ERASE: if (frame_done) state <= PG_ERASE;
                PG_ERASE:      if (frame_done) state <= PG_POLL_ERASE;
                PG_POLL_ERASE: if (wip_clear) state <= PG_WREN_PROG;  // Else poll again
                PG_WREN_PROG:  if (frame_done) state <= PG_PROGRAM;
                PG_PROGRAM:    if (frame_done) state <= PG_POLL_PROG;
                PG_POLL_PROG: begin
                    if (wip_clear) begin
                        state <= PG_IDLE;
                        done  <= 1'b1;
                    end
                end
                default:       state <= PG_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == PG_IDLE && start) begin
            addr_q <= cmd.addr;
            data_q <= cmd.wdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/flash_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module flash_controller (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  cmd_valid,
    input  flash_pkg::host_cmd_t  cmd,
    output logic [31:0]           rd_word,
    output logic                  rd_valid,
    output logic                  wr_done,
    output logic                  rd_busy,
    output logic                  wr_busy,
    output logic                  flash_cs_n,
    output logic                  flash_sck,
    output logic                  flash_mosi,
    input  logic                  flash_miso
);

    import flash_pkg::*;

    frame_req_t  rd_frame;
    frame_req_t  pg_frame;
    frame_req_t  eng_frame;
    logic        rd_frame_req, pg_frame_req;
    logic        rd_frame_done, pg_frame_done;
    logic        eng_start, eng_done, eng_busy;
    logic [31:0] eng_rx;

    read_sequencer rd_seq_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .start      (cmd_valid && !cmd.write),
        .address    (cmd.addr),
        .busy       (rd_busy),
        .frame_req  (rd_frame_req),
        .frame      (rd_frame),
        .frame_done (rd_frame_done),
        .rx_data    (eng_rx),
        .word       (rd_word),
        .valid      (rd_valid)
    );

    program_sequencer pg_seq_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .start      (cmd_valid && cmd.write),
        .cmd        (cmd),
        .busy       (wr_busy),
        .frame_req  (pg_frame_req),
        .frame      (pg_frame),
        .frame_done (pg_frame_done),
        .rx_data    (eng_rx),
        .done       (wr_done)
    );

    // Both sequencers share one engine
    frame_arbiter arb_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .rd_req    (rd_frame_req),
        .pg_req    (pg_frame_req),
        .rd_frame  (rd_frame),
        .pg_frame  (pg_frame),
        .rd_done   (rd_frame_done),
        .pg_done   (pg_frame_done),
        .eng_busy  (eng_busy),
        .eng_done  (eng_done),
        .eng_start (eng_start),
        .eng_frame (eng_frame)
    );

    spi_frame_engine eng_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .start      (eng_start),
        .req        (eng_frame),
        .done       (eng_done),
        .rx_data    (eng_rx),
        .busy       (eng_busy),
        .flash_cs_n (flash_cs_n),
        .flash_sck  (flash_sck),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

endmodule

`default_nettype wire

/* verification/spi_flash_model.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_flash_model (
    input  logic cs_n,
    input  logic sck,
    input  logic mosi,
    output logic miso
);

    import flash_pkg::*;

    logic [31:0] mem [logic [23:0]];    // Words never written read as erased
    logic [63:0] rx_sr       = '0;
    logic [31:0] out_sr      = '0;
    logic [7:0]  opcode      = '0;
    logic [5:0]  out_idx     = '0;
    logic        miso_q      = 1'b0;
    logic        wel         = 1'b0;   // Write enable latch
    int          bit_cnt     = 0;
    int          busy_left   = 0;
    int          busy_issued = 0;      // Busy status reads handed out so far
    int          rdsr_frames = 0;

    assign miso = miso_q;

    task automatic start_busy();
        busy_left   = $urandom_range(5, 1);
        busy_issued = busy_issued + busy_left;
        wel         = 1'b0;
    endtask

    //////////////////////////////
    // Command decode on SCK rise
    //////////////////////////////

    always @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            bit_cnt = 0;
        end else begin
            rx_sr   = {rx_sr[62:0], mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                opcode = rx_sr[7:0];
                if (opcode == OP_WREN)
                    wel = 1'b1;
                if (opcode == OP_RDSR) begin
                    rdsr_frames = rdsr_frames + 1;
                    out_sr      = {7'd0, busy_left != 0, 24'd0};   // WIP is status bit 0
                    if (busy_left != 0)
                        busy_left = busy_left - 1;
                end
            end else if (bit_cnt == 32 && opcode == OP_READ) begin
                out_sr = mem.exists(rx_sr[23:0]) ? mem[rx_sr[23:0]] : 32'hFFFF_FFFF;
            end else if (bit_cnt == 32 && opcode == OP_SE && wel) begin
                for (int i = 0; i < 1024; i++)
                    mem[{rx_sr[23:12], i[9:0], 2'b00}] = 32'hFFFF_FFFF;
                start_busy();
            end else if (bit_cnt == 64 && opcode == OP_PP && wel) begin
                mem[rx_sr[55:32]] = rx_sr[31:0];
                start_busy();
            end
        end
    end

    // Read data leaves MSB first on SCK fall
    always @(negedge sck or posedge cs_n) begin
        if (cs_n) begin
            out_idx = '0;
            miso_q  = 1'b0;
        end else if (out_idx < 6'd32 && bit_cnt >= 8
                     && (opcode == OP_RDSR || (opcode == OP_READ && bit_cnt >= 32))) begin
            miso_q  = out_sr[~out_idx[4:0]];
            out_idx = out_idx + 6'd1;
        end
    end

endmodule

`default_nettype wire

/* verification/flash_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module flash_assert (
    input logic i_clk,
    input logic i_reset,
    input logic start,
    input logic done,
    input logic flash_cs_n,
    input logic flash_sck
);

    sck_idle_a: assert property (@(posedge i_clk) disable iff (i_reset)
        flash_cs_n |-> !flash_sck)
        else $error("SCK high while chip select is high");

    done_pulse_a: assert property (@(posedge i_clk) disable iff (i_reset)
        done |=> !done)
        else $error("Frame done held longer than one cycle");

    // Every frame opens from a start strobe
    cs_start_a: assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(flash_cs_n) |-> $past(start))
        else $error("Chip select fell without a start");

endmodule

bind spi_frame_engine flash_assert assert_i (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .start      (start),
    .done       (done),
    .flash_cs_n (flash_cs_n),
    .flash_sck  (flash_sck)
);

`default_nettype wire

/* verification/tb_flash_controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "flash_defs.svh"

module tb_flash_controller;

    import flash_pkg::*;

    localparam int HALF      = `FLASH_SCK_HALF;
    localparam int READ_BITS = 8 + `FLASH_ADDR_BITS + `FLASH_WORD_BITS;

    function automatic int frame_cycles(input int bits);
        return (bits * 2 + 3) * HALF;
    endfunction

    // Worst program has two WREN, SE, PP, twelve polls and one READ slipped in
    localparam int SEQ_MAX = 2 * frame_cycles(8) + frame_cycles(32) + frame_cycles(64)
                           + 12 * frame_cycles(16) + frame_cycles(READ_BITS);
    localparam int N_OPS   = 40;
    localparam int TIMEOUT = N_OPS * SEQ_MAX * 2;

    logic        i_clk;
    logic        i_reset;
    logic        cmd_valid;
    host_cmd_t   cmd;
    logic [31:0] rd_word;
    logic        rd_valid;
    logic        wr_done;
    logic        rd_busy;
    logic        wr_busy;
    logic        flash_cs_n;
    logic        flash_sck;
    logic        flash_mosi;
    logic        flash_miso;

    logic [31:0] ref_mem [logic [23:0]];
    int          errors       = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycles       = 0;
    int          rd_pulses    = 0;
    int          wr_pulses    = 0;
    int          rdsr_start;
    int          busy_start;

    flash_controller dut_i (.*);

    spi_flash_model flash_i (
        .cs_n (flash_cs_n),
        .sck  (flash_sck),
        .mosi (flash_mosi),
        .miso (flash_miso)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (rd_valid)
            rd_pulses <= rd_pulses + 1;
        if (wr_done)
            wr_pulses <= wr_pulses + 1;
        if (cycles == TIMEOUT) begin
            $display("Timeout after %0d cycles, the run hung", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Reference memory
    //////////////////////////////

    function automatic logic [31:0] ref_read(input logic [23:0] addr);
        return ref_mem.exists(addr) ? ref_mem[addr] : 32'hFFFF_FFFF;
    endfunction

    // Sector erase first and then the word
    function automatic void ref_program(input logic [23:0] addr, input logic [31:0] data);
        logic [23:0] keys [$];
        foreach (ref_mem[k])
            if (k[23:12] == addr[23:12])
                keys.push_back(k);
        foreach (keys[i])
            ref_mem.delete(keys[i]);
        ref_mem[addr] = data;
    endfunction

    function automatic logic [23:0] rand_addr();
        logic [31:0] r;
        r = $urandom();
        return {r[23:2], 2'b00};
    endfunction

    //////////////////////////////
    // Host side tasks
    //////////////////////////////

    task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
                                  input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic issue_cmd(input logic wr, input logic [23:0] addr, input logic [31:0] data);
        next_cycle();
        cmd_valid = 1'b1;
        cmd       = '{write: wr, addr: addr, wdata: data};
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic read_word(input logic [23:0] addr, output logic [31:0] data);
        issue_cmd(1'b0, addr, '0);
        while (!rd_valid)
            next_cycle();
        data = rd_word;
    endtask

    task automatic read_check(input logic [23:0] addr, input string what);
        logic [31:0] got;
        read_word(addr, got);
        compare_values(got, ref_read(addr), what);
    endtask

    task automatic start_program(input logic [23:0] addr, input logic [31:0] data);
        rdsr_start = flash_i.rdsr_frames;
        busy_start = flash_i.busy_issued;
        issue_cmd(1'b1, addr, data);
    endtask

    // One clear poll closes each of the erase and program waits
    task automatic finish_program(input logic [23:0] addr, input logic [31:0] data);
        while (!wr_done)
            next_cycle();
        ref_program(addr, data);
        compare_values(flash_i.busy_left, 0, "busy status reads left at wr_done");
        compare_values(flash_i.rdsr_frames - rdsr_start, flash_i.busy_issued - busy_start + 2,
                       "RDSR frames in one program");
    endtask

    task automatic program_word(input logic [23:0] addr, input logic [31:0] data);
        start_program(addr, data);
        finish_program(addr, data);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [23:0] a;
        logic [23:0] b;
        logic [31:0] d;
        logic [31:0] got;
        logic [23:0] keys [$];
        int          err0;
        int          pulses0;

        void'($urandom(97));
        i_reset    = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        repeat (16) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        err0    = errors;
        pulses0 = rd_pulses;
        for (int i = 0; i < 6; i++)
            read_check(rand_addr(), "unwritten word");
        next_cycle();
        compare_values(rd_pulses - pulses0, 6, "rd_valid pulses for six reads");
        end_test("read_unwritten", err0);

        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = rand_addr();
            program_word(a, $urandom());
            read_check(a, "read after program");
        end
        end_test("program_readback", err0);

        err0 = errors;
        a    = rand_addr();
        b    = {a[23:12], a[11:2] + 10'd1, 2'b00};    // Neighbour in the same sector
        program_word(a, $urandom());
        program_word(b, $urandom());
        read_word(a, got);
        compare_values(got, 32'hFFFF_FFFF, "word erased by later sector erase");
        keys.delete();
        foreach (ref_mem[k])
            keys.push_back(k);
        foreach (keys[i])
            read_check(keys[i], "word kept after erase");
        end_test("sector_erase", err0);

        err0    = errors;
        pulses0 = wr_pulses;
        for (int i = 0; i < 3; i++)
            program_word(rand_addr(), $urandom());
        next_cycle();
        compare_values(wr_pulses - pulses0, 3, "wr_done pulses for three programs");
        end_test("status_polling", err0);

        err0 = errors;
        for (int i = 0; i < 2; i++) begin
            b = rand_addr();
            program_word(b, $urandom());
            a     = rand_addr();
            a[23] = ~b[23];    // Other sector
            d     = $urandom();
            start_program(a, d);
            read_word(b, got);
            compare_values(got, ref_read(b), "read during program");
            compare_values(32'(wr_busy), 32'd1, "program still running at rd_valid");
            finish_program(a, d);
        end
        end_test("read_during_program", err0);

        err0    = errors;
        a       = rand_addr();
        b       = rand_addr();
        program_word(a, $urandom());    // First read must differ from an erased word
        pulses0 = rd_pulses;
        issue_cmd(1'b0, a, '0);
        issue_cmd(1'b0, b, '0);    // Lands while rd_busy is high
        while (!rd_valid)
            next_cycle();
        compare_values(rd_word, ref_read(a), "first read served");
        repeat (2 * frame_cycles(READ_BITS))
            @(posedge i_clk);
        #1;
        compare_values(rd_pulses - pulses0, 1, "rd_valid pulses after ignored strobe");
        compare_values(32'(rd_busy), 32'd0, "read sequencer idle");
        end_test("busy_ignore", err0);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/flash_pkg.sv
hdl/spi_frame_engine.sv
hdl/frame_arbiter.sv
hdl/read_sequencer.sv
hdl/program_sequencer.sv
hdl/flash_controller.sv
verification/spi_flash_model.sv
verification/flash_assert.sv
verification/tb_flash_controller.sv

/* Makefile */
TOP = tb_flash_controller

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

obj_dir/V$(TOP): vlog.f hdl/*.sv hdl/*.svh verification/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir
